/* dv/lsu_checker.sv */
`include "lsu_defs.svh"

module lsu_checker
(
    input  logic                        CLK,
    input  logic                        RST,
    input  lsu_types_pkg::mem_op_t      issue_op,
    input  logic                        dcache_ready,
    input  dcache_bus_pkg::dcache_req_t dcache_req,
    input  logic                        wb_valid,
    input  lsu_types_pkg::reg_idx_t     wb_rd,
    input  lsu_types_pkg::word_t        wb_data,
    input  lsu_types_pkg::word_t        ret_addr,
    input  logic                        test_done,
    output logic                        report_done,
    output int                          error_total
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int id_store_req = 0;
    localparam int id_load_req  = 1;
    localparam int id_load_wb   = 2;
    localparam int id_result_wb = 3;
    localparam int id_stall     = 4;
    localparam int id_ret_addr  = 5;

    typedef struct packed
    {
        lsu_types_pkg::op_kind_e kind;
        logic                    valid;
        lsu_types_pkg::reg_idx_t rd;
        lsu_types_pkg::word_t    data;
    } wb_exp_t;

    wb_exp_t              pipe_q [$];
    wb_exp_t              exp_wb;
    lsu_types_pkg::word_t exp_ret;
    lsu_types_pkg::word_t model_mem [16];
    logic                 held;
    int                   checks [6];
    int                   errors [6];
    string                names [6] = '{"store requests", "load requests", "load writeback",
                                        "result writeback", "stall behavior", "return address"};

    // Same power-up contents as the cache model
    function automatic lsu_types_pkg::word_t fill_word(int idx);
        return 32'hC3A5_0F1E ^ (32'(idx) * 32'h0097_1F25);
    endfunction

    function automatic dcache_bus_pkg::byte_en_t store_enables(lsu_types_pkg::mem_size_e sz,
            logic [1:0] off);
        case (sz)
            lsu_types_pkg::size_word:  return 4'b1111;
            lsu_types_pkg::size_half,
            lsu_types_pkg::size_uhalf: return (off == 2'd3) ? 4'b0000 : (4'b0011 << off);
            default:                   return 4'b0001 << off;
        endcase
    endfunction

    function automatic lsu_types_pkg::word_t load_extract(lsu_types_pkg::word_t w,
            logic [1:0] off, lsu_types_pkg::mem_size_e sz);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(w >> (8 * int'(off)));
        h = (off == 2'd3) ? 16'h0000 : 16'(w >> (8 * int'(off)));
        case (sz)
            lsu_types_pkg::size_byte:  return {{24{b[7]}}, b};
            lsu_types_pkg::size_ubyte: return {24'h000000, b};
            lsu_types_pkg::size_half:  return {{16{h[15]}}, h};
            lsu_types_pkg::size_uhalf: return {16'h0000, h};
            default:                   return w;
        endcase
    endfunction

    task automatic check_value(input int id, input string name, input logic [31:0] got,
            input logic [31:0] exp);
        checks[id] = checks[id] + 1;
        if (got !== exp)
        begin
            errors[id] = errors[id] + 1;
            $display("[ERROR] %0t ns: %s expected %h, got %h", $time, name, exp, got);
        end
    endtask

    ////////////////////
    // Issue side
    ////////////////////

    task automatic accept_op();
        wb_exp_t                  entry;
        logic [1:0]               off;
        logic [3:0]               idx;
        dcache_bus_pkg::byte_en_t en;
        lsu_types_pkg::word_t     wd;
        off = issue_op.value[1:0];
        idx = issue_op.value[5:2];
        entry = {issue_op.kind, 1'b0, issue_op.rd, issue_op.value};
        if (issue_op.kind == lsu_types_pkg::op_store)
        begin
            en = store_enables(issue_op.size, off);
            wd = issue_op.store_data << (8 * int'(off));
            check_value(id_store_req, "dcache_req.cmd", 32'(dcache_req.cmd),
                        32'(dcache_bus_pkg::dc_write));
            check_value(id_store_req, "dcache_req.addr", dcache_req.addr,
                        {issue_op.value[31:2], 2'b00});
            check_value(id_store_req, "dcache_req.byte_en", 32'(dcache_req.byte_en), 32'(en));
            check_value(id_store_req, "dcache_req.wdata", dcache_req.wdata, wd);
            for (int b = 0; b < 4; b++)
                if (en[b])
                    model_mem[idx][8*b +: 8] = wd[8*b +: 8];
        end
        else if (issue_op.kind == lsu_types_pkg::op_load)
        begin
            check_value(id_load_req, "dcache_req.cmd", 32'(dcache_req.cmd),
                        32'(dcache_bus_pkg::dc_read));
            check_value(id_load_req, "dcache_req.addr", dcache_req.addr,
                        {issue_op.value[31:2], 2'b00});
            entry.valid = (issue_op.rd != '0);
            entry.data  = load_extract(model_mem[idx], off, issue_op.size);
        end
        else
        begin
            check_value(id_load_req, "dcache_req.cmd", 32'(dcache_req.cmd),
                        32'(dcache_bus_pkg::dc_idle));
            entry.valid = (issue_op.kind == lsu_types_pkg::op_result) && (issue_op.rd != '0);
        end
        // Written back three accepted edges later
        pipe_q.push_back(entry);
        exp_wb = pipe_q.pop_front();
        if (exp_wb.valid && exp_wb.rd == lsu_types_pkg::reg_idx_t'(`LSU_RA_REG))
            exp_ret = exp_wb.data;
    endtask

    ////////////////////
    // Per-cycle compare
    ////////////////////

    always @(posedge CLK)
    begin
        int id;
        int total_checks;
        int total_errors;
        if (RST)
        begin
            pipe_q.delete();
            repeat (`LSU_MEM_STAGES) pipe_q.push_back(wb_exp_t'(0));
            exp_wb  = '0;
            exp_ret = '0;
            held    = 1'b0;
            for (int i = 0; i < 16; i++)
                model_mem[i] = fill_word(i);
            report_done <= 1'b0;
            error_total <= 0;
        end
        else
        begin
            if (held)
                id = id_stall;
            else if (exp_wb.kind == lsu_types_pkg::op_load)
                id = id_load_wb;
            else
                id = id_result_wb;
            check_value(id, "wb_valid", 32'(wb_valid), 32'(exp_wb.valid));
            if (exp_wb.valid)
            begin
                check_value(id, "wb_rd", 32'(wb_rd), 32'(exp_wb.rd));
                check_value(id, "wb_data", wb_data, exp_wb.data);
            end
            check_value(id_ret_addr, "ret_addr", ret_addr, exp_ret);
            if (dcache_ready)
                accept_op();
            held = !dcache_ready;
            if (test_done && !report_done)
            begin
                total_checks = 0;
                total_errors = 0;
                for (int i = 0; i < 6; i++)
                begin
                    $display("%s: %0d checks, %0d errors", names[i], checks[i], errors[i]);
                    total_checks = total_checks + checks[i];
                    total_errors = total_errors + errors[i];
                end
                $display("Totals: %0d checks, %0d errors", total_checks, total_errors);
                report_done <= 1'b1;
                error_total <= total_errors;
            end
        end
    end

endmodule

/* dv/lsu_tb.sv */
`include "lsu_defs.svh"

module lsu_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clk_period   = 40;
    localparam int n_stall_ops  = 300;
    localparam int n_steady_ops = 100;
    localparam int max_low_run  = 3;
    localparam int drain_ops    = 2 * `LSU_MEM_STAGES + 4;
    // Each op waits at most max_low_run stall cycles before its accepting edge
    localparam int watchdog_cycles = 8 + (n_stall_ops + n_steady_ops) * (max_low_run + 1) +
                                     drain_ops + 50;

    logic                        CLK;
    logic                        RST;
    lsu_types_pkg::mem_op_t      issue_op;
    logic                        dcache_ready;
    dcache_bus_pkg::dcache_req_t dcache_req;
    lsu_types_pkg::word_t        dcache_rdata;
    logic                        wb_valid;
    lsu_types_pkg::reg_idx_t     wb_rd;
    lsu_types_pkg::word_t        wb_data;
    lsu_types_pkg::word_t        ret_addr;
    logic                        test_done;
    logic                        report_done;
    int                          error_total;

    logic [31:0]          lcg_state;
    int                   low_run;
    logic                 stall_en;
    lsu_types_pkg::word_t cache_mem [16];
    lsu_types_pkg::word_t rdata_pipe [`LSU_MEM_STAGES];
    logic [3:0]           cache_idx;

    lsu_top DUT
    (
        .CLK          (CLK),
        .RST          (RST),
        .issue_op     (issue_op),
        .dcache_ready (dcache_ready),
        .dcache_req   (dcache_req),
        .dcache_rdata (dcache_rdata),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .ret_addr     (ret_addr)
    );

    lsu_checker u_checker
    (
        .CLK          (CLK),
        .RST          (RST),
        .issue_op     (issue_op),
        .dcache_ready (dcache_ready),
        .dcache_req   (dcache_req),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .ret_addr     (ret_addr),
        .test_done    (test_done),
        .report_done  (report_done),
        .error_total  (error_total)
    );

    function automatic logic [15:0] rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic lsu_types_pkg::word_t fill_word(int idx);
        return 32'hC3A5_0F1E ^ (32'(idx) * 32'h0097_1F25);
    endfunction

    function automatic logic next_ready();
        logic [15:0] r;
        r = rand16();
        if (stall_en && low_run < max_low_run && r[1:0] == 2'b00)
        begin
            low_run = low_run + 1;
            return 1'b0;
        end
        low_run = 0;
        return 1'b1;
    endfunction

    function automatic lsu_types_pkg::mem_op_t random_op();
        lsu_types_pkg::mem_op_t op;
        logic [15:0]            r;
        r = rand16();
        case (r[2:0])
            3'd0:             op.kind = lsu_types_pkg::op_idle;
            3'd1, 3'd2:       op.kind = lsu_types_pkg::op_result;
            3'd3, 3'd4, 3'd5: op.kind = lsu_types_pkg::op_load;
            default:          op.kind = lsu_types_pkg::op_store;
        endcase
        case (r[5:3])
            3'd0, 3'd7: op.size = lsu_types_pkg::size_byte;
            3'd1, 3'd6: op.size = lsu_types_pkg::size_half;
            3'd2, 3'd5: op.size = lsu_types_pkg::size_word;
            3'd3:       op.size = lsu_types_pkg::size_ubyte;
            default:    op.size = lsu_types_pkg::size_uhalf;
        endcase
        // Sixteen words from 0x1000, so loads often hit earlier stores
        op.value = {26'h0000040, r[9:6], r[11:10]};
        if (op.kind == lsu_types_pkg::op_result)
            op.value = {rand16(), rand16()};
        op.store_data = {rand16(), rand16()};
        case (r[13:12])
            2'b00:   op.rd = lsu_types_pkg::reg_idx_t'(`LSU_RA_REG);
            2'b01:   op.rd = '0;
            default: op.rd = 5'(rand16());
        endcase
        return op;
    endfunction

    // Holds the op until an edge with ready high takes it
    task automatic issue_one(input lsu_types_pkg::mem_op_t op);
        logic accepted;
        issue_op     <= op;
        dcache_ready <= next_ready();
        accepted = 1'b0;
        while (!accepted)
        begin
            @(posedge CLK);
            accepted = dcache_ready;
            if (!accepted)
                dcache_ready <= next_ready();
        end
    endtask

    ////////////////////
    // Data cache model
    ////////////////////

    assign cache_idx    = dcache_req.addr[5:2];
    assign dcache_rdata = rdata_pipe[`LSU_MEM_STAGES-1];

    always @(posedge CLK)
    begin
        if (RST)
        begin
            for (int i = 0; i < 16; i++)
                cache_mem[i] <= fill_word(i);
            for (int i = 0; i < `LSU_MEM_STAGES; i++)
                rdata_pipe[i] <= '0;
        end
        else if (dcache_ready)
        begin
            if (dcache_req.cmd == dcache_bus_pkg::dc_write)
                for (int b = 0; b < 4; b++)
                    if (dcache_req.byte_en[b])
                        cache_mem[cache_idx][8*b +: 8] <= dcache_req.wdata[8*b +: 8];
            // Read latency of three accepted edges
            rdata_pipe[0] <= cache_mem[cache_idx];
            for (int i = 1; i < `LSU_MEM_STAGES; i++)
                rdata_pipe[i] <= rdata_pipe[i-1];
        end
    end

    ////////////////////
    // Clock, stimulus
    ////////////////////

    initial
    begin
        CLK = 1'b0;
        forever #(clk_period / 2) CLK = ~CLK;
    end

    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("Watchdog timeout: run did not finish within %0d cycles", watchdog_cycles);
        $display("Done: errors found");
        $finish;
    end

    initial
    begin
        lsu_types_pkg::mem_op_t idle_op;
        idle_op   = '0;
        lcg_state = 32'd13;
        low_run   = 0;
        stall_en  = 1'b1;
        RST          <= 1'b1;
        issue_op     <= '0;
        dcache_ready <= 1'b0;
        test_done    <= 1'b0;
        repeat (8) @(posedge CLK);
        RST <= 1'b0;
        repeat (n_stall_ops) issue_one(random_op());
        // Ready held high from here on
        stall_en = 1'b0;
        repeat (n_steady_ops) issue_one(random_op());
        repeat (drain_ops) issue_one(idle_op);
        test_done <= 1'b1;
        while (report_done !== 1'b1)
            @(posedge CLK);
        if (error_total == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

/* lsu_top.f */
+incdir+verilog
verilog/lsu_types_pkg.sv
verilog/dcache_bus_pkg.sv
verilog/store_align.sv
verilog/mem_pipeline.sv
verilog/writeback_stage.sv
verilog/lsu_top.sv
dv/lsu_checker.sv
dv/lsu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module lsu_tb --Mdir obj_dir -o lsu_sim \
    -f lsu_top.f

./obj_dir/lsu_sim > sim.log 2>&1
cat sim.log

if grep -qF "Done: errors found" sim.log; then
    echo "Simulation reported failures, see sim.log"
    exit 1
fi
echo "Simulation passed"

/* verilog/dcache_bus_pkg.sv */
`include "lsu_defs.svh"

package dcache_bus_pkg;

    ////////////////////
    // Request command
    ////////////////////

    // Flush kept for the cache side, never issued here
    typedef enum logic [1:0]
    {
        dc_idle  = 2'b00,
        dc_read  = 2'b01,
        dc_write = 2'b10,
        dc_flush = 2'b11
    } dcache_cmd_e;

    // One enable per byte lane
    typedef logic [`LSU_XLEN/8-1:0] byte_en_t;

    ////////////////////
    // Request bundle
    ////////////////////

    // Word aligned address, data already in its byte lanes
    typedef struct packed
    {
        dcache_cmd_e          cmd;
        lsu_types_pkg::addr_t addr;
        byte_en_t             byte_en;
        lsu_types_pkg::word_t wdata;
    } dcache_req_t;

endpackage

/* verilog/lsu_defs.svh */
`ifndef LSU_DEFS_SVH
`define LSU_DEFS_SVH

////////////////////
// Datapath widths
////////////////////

// Data word and byte address width
`define LSU_XLEN 32

// Destination register index
`define LSU_REG_IDX_W 5

////////////////////
// Memory pipeline
////////////////////

// Stages mem1 to mem3, also the cache read latency in accepted edges
`define LSU_MEM_STAGES 3

// Writes to this register update the return address
`define LSU_RA_REG 1

`endif

/* verilog/lsu_top.sv */
module lsu_top
(
    input  logic                        CLK,
    input  logic                        RST,

    // Issue side
    input  lsu_types_pkg::mem_op_t      issue_op,
    input  logic                        dcache_ready,

    // Data cache
    output dcache_bus_pkg::dcache_req_t dcache_req,
    input  lsu_types_pkg::word_t        dcache_rdata,

    // Register file writeback
    output logic                        wb_valid,
    output lsu_types_pkg::reg_idx_t     wb_rd,
    output lsu_types_pkg::word_t        wb_data,
    output lsu_types_pkg::word_t        ret_addr
);

    lsu_types_pkg::stage_op_t mem3_op;

    ////////////////////
    // Issue cycle
    ////////////////////

    store_align u_store_align
    (
        .issue_op   (issue_op),
        .dcache_req (dcache_req)
    );

    ////////////////////
    // mem1 to mem3
    ////////////////////

    mem_pipeline u_mem_pipeline
    (
        .CLK          (CLK),
        .RST          (RST),
        .dcache_ready (dcache_ready),
        .issue_op     (issue_op),
        .mem3_op      (mem3_op)
    );

    ////////////////////
    // Writeback
    ////////////////////

    writeback_stage u_writeback_stage
    (
        .CLK          (CLK),
        .RST          (RST),
        .dcache_ready (dcache_ready),
        .mem3_op      (mem3_op),
        .dcache_rdata (dcache_rdata),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .ret_addr     (ret_addr)
    );

endmodule

/* verilog/lsu_types_pkg.sv */
`include "lsu_defs.svh"

package lsu_types_pkg;

    typedef logic [`LSU_XLEN-1:0]      word_t;
    typedef logic [`LSU_XLEN-1:0]      addr_t;
    typedef logic [`LSU_REG_IDX_W-1:0] reg_idx_t;

    typedef enum logic [1:0]
    {
        op_idle   = 2'b00,
        op_result = 2'b01,
        op_load   = 2'b10,
        op_store  = 2'b11
    } op_kind_e;

    // Width codes, bit 2 marks the unsigned loads
    typedef enum logic [2:0]
    {
        size_byte  = 3'b000,
        size_half  = 3'b001,
        size_word  = 3'b010,
        size_ubyte = 3'b100,
        size_uhalf = 3'b101
    } mem_size_e;

    // Issue port, value is the address for loads and stores, the result otherwise
    typedef struct packed
    {
        op_kind_e  kind;
        mem_size_e size;
        word_t     value;
        word_t     store_data;
        reg_idx_t  rd;
    } mem_op_t;

    // What mem1 to mem3 carry
    typedef struct packed
    {
        op_kind_e  kind;
        mem_size_e size;
        word_t     value;
        reg_idx_t  rd;
    } stage_op_t;

endpackage

/* verilog/mem_pipeline.sv */
`include "lsu_defs.svh"

module mem_pipeline
(
    input  logic                     CLK,
    input  logic                     RST,
    input  logic                     dcache_ready,
    input  lsu_types_pkg::mem_op_t   issue_op,
    output lsu_types_pkg::stage_op_t mem3_op
);

    lsu_types_pkg::stage_op_t entry_op;
    lsu_types_pkg::stage_op_t stage_q [`LSU_MEM_STAGES];

    ////////////////////
    // Stage entry
    ////////////////////

    // Store data left with the cache request
    always_comb
    begin
        entry_op.kind  = issue_op.kind;
        entry_op.size  = issue_op.size;
        entry_op.value = issue_op.value;
        entry_op.rd    = issue_op.rd;
    end

    ////////////////////
    // mem1 to mem3
    ////////////////////

    // Whole pipe frozen while the cache is busy
    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            for (int i = 0; i < `LSU_MEM_STAGES; i++)
            begin
                stage_q[i].kind <= lsu_types_pkg::op_idle;
            end
        end
        else if (dcache_ready)
        begin
            stage_q[0] <= entry_op;
            for (int i = 1; i < `LSU_MEM_STAGES; i++)
            begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Load data for this op arrives from the cache here
    assign mem3_op = stage_q[`LSU_MEM_STAGES-1];

endmodule

/* verilog/store_align.sv */
`include "lsu_defs.svh"

module store_align
(
    input  lsu_types_pkg::mem_op_t      issue_op,
    output dcache_bus_pkg::dcache_req_t dcache_req
);

    logic [1:0]               offset;
    dcache_bus_pkg::byte_en_t store_en;

    assign offset = issue_op.value[1:0];

    // Lane enables by access size and offset
    always_comb
    begin
        case (issue_op.size)
            lsu_types_pkg::size_word:
            begin
                store_en = 4'b1111;
            end
            lsu_types_pkg::size_half, lsu_types_pkg::size_uhalf:
            begin
                case (offset)
                    2'b00:   store_en = 4'b0011;
                    2'b01:   store_en = 4'b0110;
                    2'b10:   store_en = 4'b1100;
                    default: store_en = 4'b0000;
                endcase
            end
            lsu_types_pkg::size_byte, lsu_types_pkg::size_ubyte:
            begin
                store_en = 4'b0001 << offset;
            end
            default:
            begin
                store_en = 4'b0000;
            end
        endcase
    end

    ////////////////////
    // Request
    ////////////////////

    always_comb
    begin
        dcache_req.addr    = {issue_op.value[`LSU_XLEN-1:2], 2'b00};
        dcache_req.byte_en = '0;
        dcache_req.wdata   = '0;
        case (issue_op.kind)
            lsu_types_pkg::op_load:
            begin
                dcache_req.cmd = dcache_bus_pkg::dc_read;
            end
            lsu_types_pkg::op_store:
            begin
                dcache_req.cmd     = dcache_bus_pkg::dc_write;
                dcache_req.byte_en = store_en;
                // Low bytes of the store move up into the addressed lane
                dcache_req.wdata   = issue_op.store_data << {offset, 3'b000};
            end
            default:
            begin
                dcache_req.cmd = dcache_bus_pkg::dc_idle;
            end
        endcase
    end

endmodule

/* verilog/writeback_stage.sv */
`include "lsu_defs.svh"

module writeback_stage
(
    input  logic                     CLK,
    input  logic                     RST,
    input  logic                     dcache_ready,
    input  lsu_types_pkg::stage_op_t mem3_op,
    input  lsu_types_pkg::word_t     dcache_rdata,
    output logic                     wb_valid,
    output lsu_types_pkg::reg_idx_t  wb_rd,
    output lsu_types_pkg::word_t     wb_data,
    output lsu_types_pkg::word_t     ret_addr
);

    lsu_types_pkg::word_t lane_data;
    lsu_types_pkg::word_t load_data;
    lsu_types_pkg::word_t wb_data_next;
    logic                 half_split;
    logic                 wb_valid_next;

    ////////////////////
    // Load extraction
    ////////////////////

    // Addressed byte lane down to bit 0
    assign lane_data  = dcache_rdata >> {mem3_op.value[1:0], 3'b000};

    // Halfword crossing the word boundary
    assign half_split = (mem3_op.value[1:0] == 2'b11);

    always_comb
    begin
        case (mem3_op.size)
            lsu_types_pkg::size_byte:
            begin
                load_data = {{(`LSU_XLEN-8){lane_data[7]}}, lane_data[7:0]};
            end
            lsu_types_pkg::size_ubyte:
            begin
                load_data = {{(`LSU_XLEN-8){1'b0}}, lane_data[7:0]};
            end
            lsu_types_pkg::size_half:
            begin
                load_data = half_split ? '0 :
                            {{(`LSU_XLEN-16){lane_data[15]}}, lane_data[15:0]};
            end
            lsu_types_pkg::size_uhalf:
            begin
                load_data = half_split ? '0 : {{(`LSU_XLEN-16){1'b0}}, lane_data[15:0]};
            end
            default:
            begin
                load_data = dcache_rdata;
            end
        endcase
    end

    assign wb_data_next  = (mem3_op.kind == lsu_types_pkg::op_load) ? load_data : mem3_op.value;

    // Stores and bubbles never write back, nor does x0
    assign wb_valid_next = ((mem3_op.kind == lsu_types_pkg::op_load) ||
                            (mem3_op.kind == lsu_types_pkg::op_result)) &&
                           (mem3_op.rd != '0);

    ////////////////////
    // Writeback regs
    ////////////////////

    always_ff @(posedge CLK)
    begin
        if (RST)
        begin
            wb_valid <= 1'b0;
            ret_addr <= '0;
        end
        else if (dcache_ready)
        begin
            wb_valid <= wb_valid_next;
            // Captured on the same edge as the writeback itself
            if (wb_valid_next && (mem3_op.rd == lsu_types_pkg::reg_idx_t'(`LSU_RA_REG)))
            begin
                ret_addr <= wb_data_next;
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (dcache_ready)
        begin
            wb_rd   <= mem3_op.rd;
            wb_data <= wb_data_next;
        end
    end

endmodule
